/* flist.f */
chan_pkg.sv
dp_ram.sv
axis_fifo.sv
phase_sequencer.sv
circ_buffer.sv
chan_input_top.sv
chan_input_asserts.sv
tb_chan_input.sv

/* Makefile */
LOG := sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_chan_input \
		-f flist.f -o sim_chan_input

run: compile
	./obj_dir/sim_chan_input > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -qF '*** TEST FAILED ***' $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -qF '*** TEST PASSED ***' $(LOG) || (echo "no pass line in $(LOG)"; exit 1)

clean:
	rm -rf obj_dir $(LOG)

/* tb_chan_input.sv */
`timescale 1ns/1ps

module tb_chan_input;

    localparam int DW = chan_pkg::DATA_WIDTH;
    localparam int WAIT_LIMIT = 2000;
    localparam int STALL_HOLD = 40;

    logic                                clk = 1'b0;
    logic                                sync_reset;
    logic                                s_tvalid;
    logic [DW-1:0]                       s_tdata;
    logic                                s_tready;
    logic [chan_pkg::FFT_SIZE_WIDTH-1:0] fft_size;
    logic                                m_tvalid;
    logic [DW-1:0]                       m_tdata;
    logic [chan_pkg::ADDR_WIDTH-1:0]     m_phase;
    logic                                m_tlast;
    logic                                m_tready = 1'b0;

    // 0 holds m_tready low, 1 holds it high, 2 randomizes it
    int ready_mode = 0;

    // accepted samples in order, plus size and start index of each frame
    logic [DW-1:0] sent_data[$];
    int            frame_sizes[$];
    int            frame_bases[$];

    int out_frame = 0;
    int out_addr = 0;
    int words_seen = 0;
    int checks = 0;
    int errors = 0;
    int tests_run = 0;

    always #2 clk = ~clk;

    chan_input_top i_dut (
        .clk       (clk),
        .sync_reset(sync_reset),
        .s_tvalid  (s_tvalid),
        .s_tdata   (s_tdata),
        .s_tready  (s_tready),
        .fft_size  (fft_size),
        .m_tvalid  (m_tvalid),
        .m_tdata   (m_tdata),
        .m_phase   (m_phase),
        .m_tlast   (m_tlast),
        .m_tready  (m_tready)
    );

    always @(posedge clk) begin
        case (ready_mode)
            0: m_tready <= 1'b0;
            1: m_tready <= 1'b1;
            default: m_tready <= ($urandom % 3) != 0;
        endcase
    end

    task automatic abort_run(input string what);
        $display("timeout at %0t: %s", $time, what);
        $display("*** TEST FAILED ***");
        $finish;
    endtask

    // even frames come out in phase order, odd frames rotated by N/2
    function automatic logic [DW-1:0] expected_data(input int frame_idx, input int addr);
        int n;
        int p;
        n = frame_sizes[frame_idx];
        if (frame_idx % 2 == 0) begin
            p = addr;
        end else begin
            p = (addr + n - n / 2) % n;
        end
        return sent_data[frame_bases[frame_idx] + p];
    endfunction

    task automatic compare_word();
        logic [DW-1:0] exp_data;
        logic          exp_last;
        int            n;
        checks++;
        words_seen++;
        assert (out_frame < frame_sizes.size()) else begin
            $display("unexpected output word at %0t, every sent frame is already out", $time);
            errors++;
        end
        if (out_frame < frame_sizes.size()) begin
            n = frame_sizes[out_frame];
            exp_data = expected_data(out_frame, out_addr);
            exp_last = (out_addr == n - 1);
            assert (int'(m_phase) == out_addr) else begin
                $display("Error at %0t: m_phase is %0d, expected %0d", $time, m_phase, out_addr);
                errors++;
            end
            assert (m_tdata == exp_data) else begin
                $display("Error at %0t: m_tdata is %h, expected %h", $time, m_tdata, exp_data);
                errors++;
            end
            assert (m_tlast == exp_last) else begin
                $display("Error at %0t: m_tlast is %b, expected %b", $time, m_tlast, exp_last);
                errors++;
            end
            out_addr++;
            if (out_addr == n) begin
                out_addr = 0;
                out_frame++;
            end
        end
    endtask

    always @(posedge clk) begin
        if (!sync_reset && m_tvalid && m_tready) begin
            compare_word();
        end
    end

    task automatic send_frames(input int count, input int size, input bit gaps);
        logic [DW-1:0] word;
        int            f;
        int            i;
        int            gap;
        int            waited;
        for (f = 0; f < count; f++) begin
            frame_sizes.push_back(size);
            frame_bases.push_back(sent_data.size());
            for (i = 0; i < size; i++) begin
                gap = gaps ? $urandom % 3 : 0;
                if (gap != 0) begin
                    s_tvalid <= 1'b0;
                    repeat (gap) @(posedge clk);
                end
                word = $urandom;
                s_tvalid <= 1'b1;
                s_tdata  <= word;
                waited = 0;
                @(posedge clk);
                while (!s_tready && waited < WAIT_LIMIT) begin
                    @(posedge clk);
                    waited++;
                end
                if (!s_tready) begin
                    abort_run("s_tready never rose for the next sample");
                end
                sent_data.push_back(word);
            end
        end
        s_tvalid <= 1'b0;
    endtask

    task automatic wait_for_drain();
        int waited;
        waited = 0;
        while (words_seen < sent_data.size() && waited < WAIT_LIMIT) begin
            @(posedge clk);
            waited++;
        end
        if (words_seen < sent_data.size()) begin
            abort_run("output did not drain");
        end
        // let the read fsm and fifo head settle
        repeat (4) @(posedge clk);
    endtask

    task automatic wait_for_stall();
        int waited;
        waited = 0;
        @(posedge clk);
        while (s_tready && waited < WAIT_LIMIT) begin
            @(posedge clk);
            waited++;
        end
        if (s_tready) begin
            abort_run("s_tready never fell with m_tready held low");
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        tests_run++;
        if (errors == errors_before) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            $display("test %0d %s: %0d errors", tests_run, name, errors - errors_before);
        end
    endtask

    initial begin
        int errors_before;
        void'($urandom(14080));
        sync_reset = 1'b1;
        s_tvalid   = 1'b0;
        s_tdata    = '0;
        fft_size   = 12'd16;
        repeat (3) @(posedge clk);
        sync_reset <= 1'b0;
        @(posedge clk);

        errors_before = errors;
        checks += 2;
        assert (m_tvalid == 1'b0) else begin
            $display("Error at %0t: m_tvalid is %b, expected 0", $time, m_tvalid);
            errors++;
        end
        assert (s_tready == 1'b1) else begin
            $display("Error at %0t: s_tready is %b, expected 1", $time, s_tready);
            errors++;
        end
        report_test("reset state", errors_before);

        errors_before = errors;
        ready_mode <= 1;
        send_frames(2, 16, 1'b0);
        wait_for_drain();
        report_test("two frames at size 16", errors_before);

        errors_before = errors;
        ready_mode <= 2;
        send_frames(8, 16, 1'b1);
        wait_for_drain();
        report_test("eight frames with gaps and back-pressure", errors_before);

        errors_before = errors;
        fft_size <= 12'd64;
        repeat (2) @(posedge clk);
        send_frames(2, 64, 1'b1);
        wait_for_drain();
        fft_size <= 12'd4;
        repeat (2) @(posedge clk);
        send_frames(4, 4, 1'b1);
        wait_for_drain();
        report_test("size change to 64 and 4", errors_before);

        errors_before = errors;
        fft_size <= 12'd16;
        ready_mode <= 0;
        repeat (2) @(posedge clk);
        fork
            send_frames(3, 16, 1'b0);
            begin
                wait_for_stall();
                // a word waits at the output and input stays blocked
                repeat (STALL_HOLD) begin
                    @(posedge clk);
                    checks++;
                    assert (!s_tready && m_tvalid) else begin
                        $display("stall broke while m_tready was held low at %0t", $time);
                        errors++;
                    end
                end
                ready_mode <= 2;
            end
        join
        wait_for_drain();
        report_test("output stall and release", errors_before);

        $display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

/* chan_input_asserts.sv */
`timescale 1ns/1ps

module chan_input_asserts (
    input logic                                clk,
    input logic                                sync_reset,
    input logic                                s_tvalid,
    input logic [chan_pkg::DATA_WIDTH-1:0]     s_tdata,
    input logic                                s_tready,
    input logic [chan_pkg::FFT_SIZE_WIDTH-1:0] fft_size,
    input logic                                m_tvalid,
    input logic [chan_pkg::DATA_WIDTH-1:0]     m_tdata,
    input logic [chan_pkg::ADDR_WIDTH-1:0]     m_phase,
    input logic                                m_tlast,
    input logic                                m_tready
);

    logic [chan_pkg::FFT_SIZE_WIDTH-1:0] frame_end;

    // fft_size only changes while empty, so it is the size of the frame on the output
    assign frame_end = fft_size - 1'b1;

    // source keeps its sample until it is taken
    a_in_hold: assert property (@(posedge clk) disable iff (sync_reset)
        s_tvalid && !s_tready |=> s_tvalid && $stable(s_tdata))
        else $error("input sample dropped or changed while s_tready was low");

    // output word and its tags stay put under back-pressure
    a_out_hold: assert property (@(posedge clk) disable iff (sync_reset)
        m_tvalid && !m_tready |=> m_tvalid && $stable(m_tdata) && $stable(m_phase)
            && $stable(m_tlast))
        else $error("output word dropped or changed while m_tready was low");

    a_no_out_in_reset: assert property (@(posedge clk)
        sync_reset |=> !m_tvalid)
        else $error("m_tvalid high during or right after reset");

    // tlast only on a valid word, and only on the last address of the frame
    a_last_with_valid: assert property (@(posedge clk) disable iff (sync_reset)
        m_tlast |-> m_tvalid && (m_phase == frame_end[chan_pkg::ADDR_WIDTH-1:0]))
        else $error("m_tlast high without m_tvalid or away from the frame end");

endmodule

bind chan_input_top chan_input_asserts i_asserts (
    .clk       (clk),
    .sync_reset(sync_reset),
    .s_tvalid  (s_tvalid),
    .s_tdata   (s_tdata),
    .s_tready  (s_tready),
    .fft_size  (fft_size),
    .m_tvalid  (m_tvalid),
    .m_tdata   (m_tdata),
    .m_phase   (m_phase),
    .m_tlast   (m_tlast),
    .m_tready  (m_tready)
);

/* chan_input_top.sv */
`timescale 1ns/1ps

module chan_input_top (
    input  logic                                clk,
    input  logic                                sync_reset,
    input  logic                                s_tvalid,
    input  logic [chan_pkg::DATA_WIDTH-1:0]     s_tdata,
    output logic                                s_tready,
    input  logic [chan_pkg::FFT_SIZE_WIDTH-1:0] fft_size,
    output logic                                m_tvalid,
    output logic [chan_pkg::DATA_WIDTH-1:0]     m_tdata,
    output logic [chan_pkg::ADDR_WIDTH-1:0]     m_phase,
    output logic                                m_tlast,
    input  logic                                m_tready
);

    // phase-tagged stream into the buffer
    logic                                seq_tvalid;
    logic [chan_pkg::DATA_WIDTH-1:0]     seq_tdata;
    logic [chan_pkg::ADDR_WIDTH-1:0]     seq_phase;
    logic                                seq_tready;
    logic [chan_pkg::FFT_SIZE_WIDTH-1:0] frame_size;

    phase_sequencer i_seq (
        .clk       (clk),
        .sync_reset(sync_reset),
        .s_tvalid  (s_tvalid),
        .s_tdata   (s_tdata),
        .s_tready  (s_tready),
        .fft_size  (fft_size),
        .seq_tvalid(seq_tvalid),
        .seq_tdata (seq_tdata),
        .seq_phase (seq_phase),
        .seq_tready(seq_tready),
        .frame_size(frame_size)
    );

    circ_buffer i_buf (
        .clk       (clk),
        .sync_reset(sync_reset),
        .seq_tvalid(seq_tvalid),
        .seq_tdata (seq_tdata),
        .seq_phase (seq_phase),
        .seq_tready(seq_tready),
        .frame_size(frame_size),
        .m_tvalid  (m_tvalid),
        .m_tdata   (m_tdata),
        .m_phase   (m_phase),
        .m_tlast   (m_tlast),
        .m_tready  (m_tready)
    );

endmodule

/* circ_buffer.sv */
`timescale 1ns/1ps

module circ_buffer (
    input  logic                                clk,
    input  logic                                sync_reset,
    input  logic                                seq_tvalid,
    input  logic [chan_pkg::DATA_WIDTH-1:0]     seq_tdata,
    input  logic [chan_pkg::ADDR_WIDTH-1:0]     seq_phase,
    output logic                                seq_tready,
    input  logic [chan_pkg::FFT_SIZE_WIDTH-1:0] frame_size,
    output logic                                m_tvalid,
    output logic [chan_pkg::DATA_WIDTH-1:0]     m_tdata,
    output logic [chan_pkg::ADDR_WIDTH-1:0]     m_phase,
    output logic                                m_tlast,
    input  logic                                m_tready
);

    localparam int DW = chan_pkg::DATA_WIDTH;
    localparam int AW = chan_pkg::ADDR_WIDTH;
    localparam int PD = chan_pkg::RD_PIPE_DEPTH;
    localparam int FW = DW + AW;

    logic                                almost_full;
    logic [chan_pkg::FFT_SIZE_WIDTH-1:0] size_m1;
    logic [chan_pkg::FFT_SIZE_WIDTH-1:0] size_m2;
    logic [AW-1:0]                       frame_last;
    logic [AW-1:0]                       read_last;
    logic [AW-1:0]                       half;
    logic [AW-1:0]                       rot_phase;

    // write side
    logic          take;
    logic          wr_done;
    logic          wr_side;
    logic          full0;
    logic          full1;
    logic          we0;
    logic          we1;
    logic [AW-1:0] wr_addr;
    logic [DW-1:0] wr_data;

    // read side
    chan_pkg::rd_state_t rd_state;
    chan_pkg::rd_state_t state_n;
    logic                rd_side;
    logic                side_n;
    logic                rd_en;
    logic                en_n;
    logic                rd_last;
    logic                last_n;
    logic [AW-1:0]       rd_addr;
    logic [AW-1:0]       addr_n;
    logic                read_done;
    logic [DW-1:0]       dob0;
    logic [DW-1:0]       dob1;

    // read pipeline, stage k holds a read issued k+1 cycles ago
    logic [PD-2:0]         rd_en_d;
    logic [PD-2:0]         rd_side_d;
    logic [PD-2:0]         rd_last_d;
    logic [PD-2:0][AW-1:0] rd_addr_d;
    logic [PD-3:0][DW-1:0] dob0_d;
    logic [PD-3:0][DW-1:0] dob1_d;

    logic          fifo_tvalid;
    logic          fifo_tlast;
    logic [FW-1:0] fifo_tdata;
    logic [FW-1:0] fifo_out;

    assign size_m1    = frame_size - 1'b1;
    assign size_m2    = frame_size - 2'd2;
    assign frame_last = size_m1[AW-1:0];
    assign read_last  = size_m2[AW-1:0];
    assign half       = frame_size[AW:1];

    // circular shift by N/2 for the odd bank
    assign rot_phase = (seq_phase + half) & frame_last;

    // also hold off if the target bank has not been read out yet
    assign seq_tready = ~almost_full & ~(wr_side ? full1 : full0);
    assign take       = seq_tvalid & seq_tready;
    assign wr_done    = take & (seq_phase == frame_last);

    assign read_done = (rd_state != chan_pkg::S_IDLE) & ~almost_full & (rd_addr == read_last);

    always_ff @(posedge clk or posedge sync_reset) begin
        if (sync_reset) begin
            wr_side <= 1'b0;
            full0   <= 1'b0;
            full1   <= 1'b0;
            we0     <= 1'b0;
            we1     <= 1'b0;
        end else begin
            we0 <= take & ~wr_side;
            we1 <= take & wr_side;
            if (wr_done) begin
                wr_side <= ~wr_side;
            end
            if (wr_done && !wr_side) begin
                full0 <= 1'b1;
            end else if (read_done && rd_state == chan_pkg::S_READ0) begin
                full0 <= 1'b0;
            end
            if (wr_done && wr_side) begin
                full1 <= 1'b1;
            end else if (read_done && rd_state == chan_pkg::S_READ1) begin
                full1 <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        wr_addr <= wr_side ? rot_phase : seq_phase;
        wr_data <= seq_tdata;
    end

    // read fsm, one read per cycle from the bank not being written
    always_comb begin
        state_n = rd_state;
        side_n  = rd_side;
        addr_n  = rd_addr;
        en_n    = 1'b0;
        last_n  = 1'b0;
        case (rd_state)
            chan_pkg::S_IDLE: begin
                if (!almost_full && rd_side && full0) begin
                    state_n = chan_pkg::S_READ0;
                    side_n  = 1'b0;
                    addr_n  = '0;
                    en_n    = 1'b1;
                end else if (!almost_full && !rd_side && full1) begin
                    state_n = chan_pkg::S_READ1;
                    side_n  = 1'b1;
                    addr_n  = '0;
                    en_n    = 1'b1;
                end
            end
            chan_pkg::S_READ0, chan_pkg::S_READ1: begin
                if (!almost_full) begin
                    en_n   = 1'b1;
                    addr_n = rd_addr + 1'b1;
                    if (rd_addr == read_last) begin
                        state_n = chan_pkg::S_IDLE;
                        last_n  = 1'b1;
                    end
                end
            end
            default: begin
                state_n = chan_pkg::S_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or posedge sync_reset) begin
        if (sync_reset) begin
            rd_state    <= chan_pkg::S_IDLE;
            rd_side     <= 1'b1;
            rd_addr     <= '0;
            rd_en       <= 1'b0;
            rd_last     <= 1'b0;
            rd_en_d     <= '0;
            rd_last_d   <= '0;
            fifo_tvalid <= 1'b0;
            fifo_tlast  <= 1'b0;
        end else begin
            rd_state    <= state_n;
            rd_side     <= side_n;
            rd_addr     <= addr_n;
            rd_en       <= en_n;
            rd_last     <= last_n;
            rd_en_d     <= {rd_en_d[PD-3:0], rd_en};
            rd_last_d   <= {rd_last_d[PD-3:0], rd_last};
            fifo_tvalid <= rd_en_d[PD-2];
            fifo_tlast  <= rd_en_d[PD-2] & rd_last_d[PD-2];
        end
    end

    // ram output lands with stage 0, then rides along to the last stage
    always_ff @(posedge clk) begin
        rd_side_d  <= {rd_side_d[PD-3:0], rd_side};
        rd_addr_d  <= {rd_addr_d[PD-3:0], rd_addr};
        dob0_d     <= {dob0_d[PD-4:0], dob0};
        dob1_d     <= {dob1_d[PD-4:0], dob1};
        fifo_tdata <= {rd_addr_d[PD-2], rd_side_d[PD-2] ? dob1_d[PD-3] : dob0_d[PD-3]};
    end

    dp_ram #(
        .DATA_WIDTH(DW),
        .ADDR_WIDTH(AW)
    ) i_ram0 (
        .clk  (clk),
        .wea  (we0),
        .addra(wr_addr),
        .dia  (wr_data),
        .addrb(rd_addr),
        .dob  (dob0)
    );

    dp_ram #(
        .DATA_WIDTH(DW),
        .ADDR_WIDTH(AW)
    ) i_ram1 (
        .clk  (clk),
        .wea  (we1),
        .addra(wr_addr),
        .dia  (wr_data),
        .addrb(rd_addr),
        .dob  (dob1)
    );

    // almost full throttles upstream, so the fifo never refuses a word
    axis_fifo #(
        .DATA_WIDTH(FW),
        .ADDR_WIDTH(chan_pkg::FIFO_ADDR_WIDTH)
    ) i_out_fifo (
        .clk        (clk),
        .sync_reset (sync_reset),
        .s_tvalid   (fifo_tvalid),
        .s_tdata    (fifo_tdata),
        .s_tlast    (fifo_tlast),
        .s_tready   (),
        .almost_full(almost_full),
        .m_tvalid   (m_tvalid),
        .m_tdata    (fifo_out),
        .m_tlast    (m_tlast),
        .m_tready   (m_tready)
    );

    assign m_tdata = fifo_out[DW-1:0];
    assign m_phase = fifo_out[FW-1:DW];

endmodule

/* phase_sequencer.sv */
`timescale 1ns/1ps

module phase_sequencer (
    input  logic                                clk,
    input  logic                                sync_reset,
    input  logic                                s_tvalid,
    input  logic [chan_pkg::DATA_WIDTH-1:0]     s_tdata,
    output logic                                s_tready,
    input  logic [chan_pkg::FFT_SIZE_WIDTH-1:0] fft_size,
    output logic                                seq_tvalid,
    output logic [chan_pkg::DATA_WIDTH-1:0]     seq_tdata,
    output logic [chan_pkg::ADDR_WIDTH-1:0]     seq_phase,
    input  logic                                seq_tready,
    output logic [chan_pkg::FFT_SIZE_WIDTH-1:0] frame_size
);

    logic [chan_pkg::ADDR_WIDTH-1:0]     phase;
    logic [chan_pkg::FFT_SIZE_WIDTH-1:0] size_m1;
    logic                                xfer;
    logic                                wrap;

    // sample and handshake pass straight through, tagged with the phase
    assign seq_tvalid = s_tvalid;
    assign seq_tdata  = s_tdata;
    assign seq_phase  = phase;
    assign s_tready   = seq_tready;

    assign size_m1 = frame_size - 1'b1;
    assign xfer    = s_tvalid & seq_tready;
    assign wrap    = xfer & (phase == size_m1[chan_pkg::ADDR_WIDTH-1:0]);

    always_ff @(posedge clk or posedge sync_reset) begin
        if (sync_reset) begin
            phase      <= '0;
            frame_size <= fft_size;
        end else begin
            if (xfer) begin
                phase <= wrap ? '0 : phase + 1'b1;
            end
            // new size only between frames
            // also tracks fft_size while idling at phase 0
            if (wrap || (phase == '0 && !xfer)) begin
                frame_size <= fft_size;
            end
        end
    end

endmodule

/* axis_fifo.sv */
`timescale 1ns/1ps

module axis_fifo #(
    parameter int DATA_WIDTH = chan_pkg::DATA_WIDTH,
    parameter int ADDR_WIDTH = chan_pkg::FIFO_ADDR_WIDTH
) (
    input  logic                  clk,
    input  logic                  sync_reset,
    input  logic                  s_tvalid,
    input  logic [DATA_WIDTH-1:0] s_tdata,
    input  logic                  s_tlast,
    output logic                  s_tready,
    output logic                  almost_full,
    output logic                  m_tvalid,
    output logic [DATA_WIDTH-1:0] m_tdata,
    output logic                  m_tlast,
    input  logic                  m_tready
);

    // tlast is stored as the top bit of each entry
    logic [DATA_WIDTH:0]   mem [2**ADDR_WIDTH];
    logic [ADDR_WIDTH-1:0] wr_ptr;
    logic [ADDR_WIDTH-1:0] rd_ptr;
    logic [ADDR_WIDTH:0]   count;
    logic [ADDR_WIDTH:0]   level;
    logic                  head_valid;
    logic [DATA_WIDTH-1:0] head_data;
    logic                  head_last;
    logic                  push;
    logic                  pop;

    // count hits the depth only when its top bit is set
    assign s_tready = ~count[ADDR_WIDTH];
    assign push     = s_tvalid & s_tready;

    // refill the head whenever it is empty or being taken
    assign pop = (count != '0) & (~head_valid | m_tready);

    // head register counts toward occupancy
    assign level       = count + {{ADDR_WIDTH{1'b0}}, head_valid};
    assign almost_full = (level >= chan_pkg::ALMOST_FULL_THRESH);

    assign m_tvalid = head_valid;
    assign m_tdata  = head_data;
    assign m_tlast  = head_valid & head_last;

    always_ff @(posedge clk or posedge sync_reset) begin
        if (sync_reset) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            head_valid <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + {{ADDR_WIDTH{1'b0}}, push} - {{ADDR_WIDTH{1'b0}}, pop};
            if (pop) begin
                head_valid <= 1'b1;
            end else if (m_tready) begin
                head_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= {s_tlast, s_tdata};
        end
        // first word falls through into the head register
        if (pop) begin
            {head_last, head_data} <= mem[rd_ptr];
        end
    end

endmodule

/* dp_ram.sv */
`timescale 1ns/1ps

module dp_ram #(
    parameter int DATA_WIDTH = chan_pkg::DATA_WIDTH,
    parameter int ADDR_WIDTH = chan_pkg::ADDR_WIDTH
) (
    input  logic                  clk,
    input  logic                  wea,
    input  logic [ADDR_WIDTH-1:0] addra,
    input  logic [DATA_WIDTH-1:0] dia,
    input  logic [ADDR_WIDTH-1:0] addrb,
    output logic [DATA_WIDTH-1:0] dob
);

    logic [DATA_WIDTH-1:0] mem [2**ADDR_WIDTH];

    // write on port a, registered read on port b
    // a read at the address being written returns the old word
    always_ff @(posedge clk) begin
        if (wea) begin
            mem[addra] <= dia;
        end
        dob <= mem[addrb];
    end

endmodule

/* chan_pkg.sv */
package chan_pkg;

    // complex sample, 16-bit i in the low half and 16-bit q in the high half
    localparam int DATA_WIDTH = 32;

    // fft_size runs up to 2048, so it needs 12 bits
    localparam int FFT_SIZE_WIDTH = 12;

    // bank address and commutator phase
    localparam int ADDR_WIDTH = FFT_SIZE_WIDTH - 1;

    // output fifo holds 2**4 words plus its head register
    localparam int FIFO_ADDR_WIDTH = 4;

    // leaves room for the reads still in flight when almost full rises
    localparam int ALMOST_FULL_THRESH = 8;

    // read enable to fifo write, in cycles
    localparam int RD_PIPE_DEPTH = 4;

    // bank read fsm
    typedef enum logic [1:0] {
        S_IDLE,
        S_READ0,
        S_READ1
    } rd_state_t;

endpackage
